//--- design/mips_alu.sv
// ----------------------------------------------------------
// 32-bit alu: and, or, add, sub, signed slt
// no overflow detection, add and sub simply wrap
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  alu_op_t         alu_control,
  output logic [XLEN-1:0] result,
  output logic            zero
);

  // signed compare for slt
  logic less;

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (alu_control)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      // 1 or 0 in the low bit
      ALU_SLT: result = {{(XLEN-1){1'b0}}, less};
      default: result = '0;
    endcase
  end

  // beq uses this after a subtract
  assign zero = (result == '0);

endmodule

//--- design/mips_control.sv
// ----------------------------------------------------------
// main decoder plus alu decoder, purely combinational
// unknown opcode or funct decodes as a no-op:
// no register write, no store, no branch, no jump
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_control import mips_pkg::*; (
  input  opcode_t opcode,
  input  funct_t  funct,
  output logic    mem_to_reg,
  output logic    mem_write,
  output logic    branch,
  output logic    jump,
  output logic    alu_src,
  output logic    reg_dst,
  output logic    reg_write,
  output alu_op_t alu_control
);

  // alu decoder result for r-type, plus a valid flag
  alu_op_t rtype_op;
  logic    rtype_ok;

  always_comb begin
    rtype_ok = 1'b1;
    case (funct)
      FN_ADD: rtype_op = ALU_ADD;
      FN_SUB: rtype_op = ALU_SUB;
      FN_AND: rtype_op = ALU_AND;
      FN_OR:  rtype_op = ALU_OR;
      FN_SLT: rtype_op = ALU_SLT;
      default: begin
        // unsupported funct, result is discarded
        rtype_op = ALU_ADD;
        rtype_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    // everything off unless the opcode says otherwise
    mem_to_reg  = 1'b0;
    mem_write   = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    alu_src     = 1'b0;
    reg_dst     = 1'b0;
    reg_write   = 1'b0;
    alu_control = ALU_ADD;
    case (opcode)
      OP_RTYPE: begin
        reg_dst     = 1'b1;
        reg_write   = rtype_ok;
        alu_control = rtype_op;
      end
      OP_LW: begin
        alu_src    = 1'b1;
        mem_to_reg = 1'b1;
        reg_write  = 1'b1;
      end
      OP_SW: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      OP_BEQ: begin
        // compare by subtraction, zero flag decides
        branch      = 1'b1;
        alu_control = ALU_SUB;
      end
      OP_ADDI: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      OP_J: jump = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- design/mips_cpu.sv
// ----------------------------------------------------------
// single-cycle datapath: one instruction per clock
// pc resets to 0, register and memory writes gated in reset
// no hazards, no exceptions, unknown ops just advance pc
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_cpu import mips_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  output logic [XLEN-1:0] instruction_address,
  input  logic [XLEN-1:0] instruction,
  mips_reg_if.cpu         regs,
  mips_dmem_if.cpu        dmem,
  output logic [XLEN-1:0] pc
);

  // decoded fields
  opcode_t opcode;
  funct_t  funct;

  // controls
  logic    mem_to_reg;
  logic    mem_write;
  logic    branch;
  logic    jump;
  logic    alu_src;
  logic    reg_dst;
  logic    reg_write;
  alu_op_t alu_control;

  // datapath nets
  logic [REG_ADDR_W-1:0] write_reg;
  logic [XLEN-1:0]       sign_imm;
  logic [XLEN-1:0]       src_b;
  logic [XLEN-1:0]       alu_result;
  logic                  zero;
  logic [XLEN-1:0]       result;

  // next pc nets
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] pc_branch;
  logic [XLEN-1:0] pc_jump;
  logic            pc_src;
  logic [XLEN-1:0] pc_next;

  assign opcode = opcode_t'(instruction[31:26]);
  assign funct  = funct_t'(instruction[5:0]);

  mips_control u_control (
    .opcode      (opcode),
    .funct       (funct),
    .mem_to_reg  (mem_to_reg),
    .mem_write   (mem_write),
    .branch      (branch),
    .jump        (jump),
    .alu_src     (alu_src),
    .reg_dst     (reg_dst),
    .reg_write   (reg_write),
    .alu_control (alu_control)
  );

  // fetch straight from pc
  assign instruction_address = pc;

  // rs, rt reads; rd for r-type, rt otherwise
  assign regs.a1   = instruction[25:21];
  assign regs.a2   = instruction[20:16];
  assign write_reg = reg_dst ? instruction[15:11] : instruction[20:16];
  assign regs.a3   = write_reg;

  assign sign_imm = {{(XLEN-16){instruction[15]}}, instruction[15:0]};
  assign src_b    = alu_src ? sign_imm : regs.rd2;

  mips_alu u_alu (
    .a           (regs.rd1),
    .b           (src_b),
    .alu_control (alu_control),
    .result      (alu_result),
    .zero        (zero)
  );

  // memory port, store data always rt
  assign dmem.a  = alu_result;
  assign dmem.wd = regs.rd2;
  assign dmem.we = mem_write & ~reset;

  // write back
  assign result    = mem_to_reg ? dmem.rd : alu_result;
  assign regs.wd3  = result;
  assign regs.we3  = reg_write & ~reset;

  // branch target is relative to pc+4
  assign pc_plus4  = pc + XLEN'(4);
  assign pc_branch = pc_plus4 + {sign_imm[XLEN-3:0], 2'b00};
  // jump keeps the top nibble of pc+4
  assign pc_jump   = {pc_plus4[XLEN-1:XLEN-4], instruction[25:0], 2'b00};
  assign pc_src    = branch & zero;

  always_comb begin
    if (jump) begin
      pc_next = pc_jump;
    end else if (pc_src) begin
      pc_next = pc_branch;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- design/mips_dmem.sv
// ----------------------------------------------------------
// data memory, word access only, byte address in mem.a
// low two address bits and bits above the depth ignored
// DMEM_WORDS must be a power of two, contents survive reset
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_dmem import mips_pkg::*; #(
  parameter int DMEM_WORDS = 256
) (
  input logic       clk,
  mips_dmem_if.mem  mem
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]  words [DMEM_WORDS];
  logic [IDX_W-1:0] index;

  // word index from the byte address
  assign index = mem.a[IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (mem.we) begin
      words[index] <= mem.wd;
    end
  end

  // load data same cycle
  assign mem.rd = words[index];

endmodule

//--- design/mips_imem.sv
// ----------------------------------------------------------
// instruction memory, async read by byte address bits 2 up
// load port takes a word index in load_addr, not a byte addr
// IMEM_WORDS must be a power of two, contents survive reset
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_imem import mips_pkg::*; #(
  parameter int IMEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            load_we,
  input  logic [XLEN-1:0] load_addr,
  input  logic [XLEN-1:0] load_data,
  input  logic [XLEN-1:0] address,
  output logic [XLEN-1:0] instruction
);

  localparam int IDX_W = $clog2(IMEM_WORDS);

  logic [XLEN-1:0] words [IMEM_WORDS];

  // program load, used while the core sits in reset
  always_ff @(posedge clk) begin
    if (load_we) begin
      words[load_addr[IDX_W-1:0]] <= load_data;
    end
  end

  // upper address bits ignored, so fetch wraps
  assign instruction = words[address[IDX_W+1:2]];

endmodule

//--- design/mips_interfaces.sv
// ----------------------------------------------------------
// register file and data memory port bundles
// all signals are plain levels, no handshake
// reads are combinational, writes land on the clock edge
// ----------------------------------------------------------
`timescale 1ns/1ps

interface mips_reg_if import mips_pkg::*; ();
  // read ports
  logic [REG_ADDR_W-1:0] a1;
  logic [REG_ADDR_W-1:0] a2;
  logic [XLEN-1:0]       rd1;
  logic [XLEN-1:0]       rd2;
  // write port
  logic [REG_ADDR_W-1:0] a3;
  logic                  we3;
  logic [XLEN-1:0]       wd3;

  modport cpu (output a1, a2, a3, we3, wd3, input rd1, rd2);
  modport rf  (input a1, a2, a3, we3, wd3, output rd1, rd2);
endinterface

interface mips_dmem_if import mips_pkg::*; ();
  // byte address, word aligned in practice
  logic [XLEN-1:0] a;
  logic            we;
  logic [XLEN-1:0] wd;
  logic [XLEN-1:0] rd;

  modport cpu (output a, we, wd, input rd);
  modport mem (input a, we, wd, output rd);
endinterface

//--- design/mips_pkg.sv
// ----------------------------------------------------------
// shared types for the single-cycle MIPS subset
// opcode and funct values follow the standard MIPS encoding
// only add, sub, and, or, slt, addi, lw, sw, beq and j exist
// ----------------------------------------------------------
package mips_pkg;

  // data path and address width
  localparam int XLEN = 32;
  // register number width, 32 registers
  localparam int REG_ADDR_W = 5;

  // instruction bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_ADDI  = 6'h08,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_t;

  // instruction bits 5:0, r-type only
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_t;

  // alu select, same codes as the classic textbook decoder
  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } alu_op_t;

endpackage

//--- design/mips_register_file.sv
// ----------------------------------------------------------
// 32 x 32 register file, two async reads, one sync write
// r0 reads zero and ignores writes
// all registers clear on synchronous reset
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_register_file import mips_pkg::*; (
  input logic       clk,
  input logic       reset,
  mips_reg_if.rf    rf
);

  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.we3 && (rf.a3 != '0)) begin
      // writes to r0 dropped here
      regs[rf.a3] <= rf.wd3;
    end
  end

  // combinational reads, r0 forced to zero
  assign rf.rd1 = (rf.a1 == '0) ? '0 : regs[rf.a1];
  assign rf.rd2 = (rf.a2 == '0) ? '0 : regs[rf.a2];

endmodule

//--- design/mips_top.sv
// ----------------------------------------------------------
// single-cycle MIPS subset, Harvard memories
// load the program through load_* while reset is high
// dmem_* mirror the store port for observation only
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_top import mips_pkg::*; #(
  parameter int IMEM_WORDS = 256,
  parameter int DMEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            load_we,
  input  logic [XLEN-1:0] load_addr,
  input  logic [XLEN-1:0] load_data,
  output logic [XLEN-1:0] pc,
  output logic            dmem_we,
  output logic [XLEN-1:0] dmem_addr,
  output logic [XLEN-1:0] dmem_wdata
);

  // fetch path
  logic [XLEN-1:0] instruction_address;
  logic [XLEN-1:0] instruction;

  mips_reg_if  reg_bus ();
  mips_dmem_if dmem_bus ();

  mips_cpu u_cpu (
    .clk                 (clk),
    .reset               (reset),
    .instruction_address (instruction_address),
    .instruction         (instruction),
    .regs                (reg_bus.cpu),
    .dmem                (dmem_bus.cpu),
    .pc                  (pc)
  );

  mips_register_file u_register_file (
    .clk   (clk),
    .reset (reset),
    .rf    (reg_bus.rf)
  );

  mips_imem #(
    .IMEM_WORDS (IMEM_WORDS)
  ) u_imem (
    .clk         (clk),
    .load_we     (load_we),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .address     (instruction_address),
    .instruction (instruction)
  );

  mips_dmem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_dmem (
    .clk (clk),
    .mem (dmem_bus.mem)
  );

  // store port copies
  assign dmem_we    = dmem_bus.we;
  assign dmem_addr  = dmem_bus.a;
  assign dmem_wdata = dmem_bus.wd;

endmodule

//--- dv/mips_props.sv
// ----------------------------------------------------------
// properties of the single-cycle core, bound into mips_cpu
// pc rules hold outside reset, pc is unknown before reset
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_props import mips_pkg::*; (
  input logic            clk,
  input logic            reset,
  input logic [XLEN-1:0] pc,
  input opcode_t         opcode,
  input logic            taken,
  input logic            store_en,
  input logic            reg_we
);

  // no write leaves the core in reset
  assert property (@(posedge clk) reset |-> !store_en && !reg_we)
    else $error("write enable high during reset");

  assert property (@(posedge clk) reset |=> pc == '0)
    else $error("pc not zero after a reset cycle");

  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc not word aligned");

  // fall through, neither taken beq nor j
  assert property (@(posedge clk) disable iff (reset)
    !(taken || opcode == OP_J) |=> pc == $past(pc) + XLEN'(4))
    else $error("pc did not advance by 4");

endmodule

bind mips_cpu mips_props u_props (
  .clk      (clk),
  .reset    (reset),
  .pc       (pc),
  .opcode   (opcode),
  .taken    (pc_src),
  .store_en (dmem.we),
  .reg_we   (regs.we3)
);

//--- dv/mips_tb.sv
// ----------------------------------------------------------
// directed tests for mips_top against an ISA model
// every program ends in a jump to itself, which ends its run
// data memory is never cleared so tests use separate addresses
// ----------------------------------------------------------
`timescale 1ns/1ps

module mips_tb;

  localparam int CLK_PERIOD = 4;
  // seven runs of under 100 cycles each including loads
  localparam int WATCHDOG_NS = 7 * 100 * CLK_PERIOD + 200;

  // opcode and funct encodings
  localparam logic [5:0] ADDI_OP = 6'h08;
  localparam logic [5:0] LW_OP   = 6'h23;
  localparam logic [5:0] SW_OP   = 6'h2b;
  localparam logic [5:0] BEQ_OP  = 6'h04;
  localparam logic [5:0] ADD_FN  = 6'h20;
  localparam logic [5:0] SUB_FN  = 6'h22;
  localparam logic [5:0] AND_FN  = 6'h24;
  localparam logic [5:0] OR_FN   = 6'h25;
  localparam logic [5:0] SLT_FN  = 6'h2a;

  logic        clk;
  logic        reset;
  logic        load_we;
  logic [31:0] load_addr;
  logic [31:0] load_data;
  logic [31:0] pc;
  logic        dmem_we;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;

  // program image, halt address and model state
  logic [31:0] prog [$];
  logic [31:0] halt_pc;
  logic [31:0] mregs [32];
  logic [31:0] mmem [logic [31:0]];
  logic [31:0] mpc;
  logic [15:0] lfsr = 16'd86;

  mips_top UUT (
    .clk        (clk),
    .reset      (reset),
    .load_we    (load_we),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .pc         (pc),
    .dmem_we    (dmem_we),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci taps 16 14 13 11 with one step per bit taken
  function automatic int random_imm();
    logic [15:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < 16; i++) begin
      fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      value = {value[14:0], fb};
    end
    return int'($signed(value));
  endfunction

  function automatic logic [31:0] rtype_word(int rs, int rt, int rd, logic [5:0] fn);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
  endfunction

  function automatic logic [31:0] itype_word(logic [5:0] op, int rs, int rt, int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  // target is a word index
  function automatic logic [31:0] jump_word(int index);
    return {6'h02, 26'(index)};
  endfunction

  function automatic void add_halt();
    halt_pc = 32'(prog.size() * 4);
    prog.push_back(jump_word(prog.size()));
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // one instruction of the ISA model and its expected store
  task automatic model_step(output logic st, output logic [31:0] sa, output logic [31:0] sd);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] pc4;
    logic [31:0] res;
    logic [4:0]  dst;
    logic        wr;
    w = prog[mpc >> 2];
    a = mregs[w[25:21]];
    b = mregs[w[20:16]];
    imm = {{16{w[15]}}, w[15:0]};
    pc4 = mpc + 32'd4;
    st = 1'b0;
    sa = '0;
    sd = '0;
    wr = 1'b1;
    dst = w[20:16];
    res = a + imm;
    mpc = pc4;
    case (w[31:26])
      6'h00: begin
        dst = w[15:11];
        case (w[5:0])
          ADD_FN: res = a + b;
          SUB_FN: res = a - b;
          AND_FN: res = a & b;
          OR_FN:  res = a | b;
          SLT_FN: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: wr = 1'b0;
        endcase
      end
      ADDI_OP: ;
      LW_OP: res = mmem[a + imm];
      SW_OP: begin
        wr = 1'b0;
        st = 1'b1;
        sa = a + imm;
        sd = b;
        mmem[sa] = b;
      end
      BEQ_OP: begin
        wr = 1'b0;
        if (a == b) mpc = pc4 + (imm << 2);
      end
      6'h02: begin
        wr = 1'b0;
        mpc = {pc4[31:28], w[25:0], 2'b00};
      end
      default: wr = 1'b0;
    endcase
    // r0 stays zero
    if (wr && dst != 5'd0) mregs[dst] = res;
  endtask

  // reset stays high through the load and 4 more cycles
  task automatic load_program();
    @(negedge clk);
    reset = 1'b1;
    foreach (prog[i]) begin
      load_we = 1'b1;
      load_addr = i;
      load_data = prog[i];
      @(negedge clk);
    end
    load_we = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  // release reset and compare each cycle 1 ns after the falling edge
  task automatic execute(input int max_cycles);
    logic        exp_we;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    logic        at_halt;
    int          n;
    foreach (mregs[i]) begin
      mregs[i] = '0;
    end
    mpc = '0;
    n = 0;
    at_halt = 1'b0;
    @(negedge clk);
    reset = 1'b0;
    while (!at_halt && n < max_cycles) begin
      #1;
      at_halt = (mpc == halt_pc);
      check_value("pc", mpc, pc);
      model_step(exp_we, exp_addr, exp_data);
      check_value("dmem_we", 32'(exp_we), 32'(dmem_we));
      if (exp_we) begin
        check_value("dmem_addr", exp_addr, dmem_addr);
        check_value("dmem_wdata", exp_data, dmem_wdata);
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic run_program();
    add_halt();
    load_program();
    execute(100);
  endtask

  task automatic test_arith();
    prog.delete();
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(itype_word(ADDI_OP, 0, r, random_imm()));
    end
    // a negative operand for slt
    prog.push_back(itype_word(ADDI_OP, 0, 5, -16));
    prog.push_back(itype_word(ADDI_OP, 0, 6, 3));
    prog.push_back(rtype_word(1, 2, 7, ADD_FN));
    prog.push_back(rtype_word(3, 4, 8, SUB_FN));
    prog.push_back(rtype_word(1, 3, 9, AND_FN));
    prog.push_back(rtype_word(2, 4, 10, OR_FN));
    prog.push_back(rtype_word(5, 6, 11, SLT_FN));
    prog.push_back(rtype_word(6, 5, 12, SLT_FN));
    prog.push_back(rtype_word(1, 2, 13, SLT_FN));
    for (int r = 7; r <= 13; r++) begin
      prog.push_back(itype_word(SW_OP, 0, r, 'h100 + 4 * r));
    end
    run_program();
  endtask

  task automatic test_load_store();
    prog.delete();
    prog.push_back(itype_word(ADDI_OP, 0, 1, 'h200));
    // offsets -4, 4 and 12 from the base in r1
    for (int i = 0; i < 3; i++) begin
      prog.push_back(itype_word(ADDI_OP, 0, 2 + i, random_imm()));
      prog.push_back(itype_word(SW_OP, 1, 2 + i, 8 * i - 4));
    end
    for (int i = 0; i < 3; i++) begin
      prog.push_back(itype_word(LW_OP, 1, 5 + i, 8 * i - 4));
      prog.push_back(rtype_word(5 + i, 1, 8 + i, SUB_FN));
      prog.push_back(itype_word(SW_OP, 1, 8 + i, 'h40 + 8 * i - 4));
    end
    run_program();
  endtask

  task automatic test_branch();
    int top;
    prog.delete();
    prog.push_back(itype_word(ADDI_OP, 0, 1, 5));
    prog.push_back(itype_word(ADDI_OP, 0, 2, 5));
    prog.push_back(itype_word(ADDI_OP, 0, 3, 7));
    // not taken and then taken over the store to 0x304
    prog.push_back(itype_word(BEQ_OP, 1, 3, 1));
    prog.push_back(itype_word(SW_OP, 0, 1, 'h300));
    prog.push_back(itype_word(BEQ_OP, 1, 2, 1));
    prog.push_back(itype_word(SW_OP, 0, 3, 'h304));
    prog.push_back(itype_word(SW_OP, 0, 2, 'h308));
    // r4 counts to 5 and a backward beq closes the loop
    top = prog.size();
    prog.push_back(itype_word(ADDI_OP, 4, 4, 1));
    prog.push_back(itype_word(SW_OP, 0, 4, 'h30c));
    prog.push_back(itype_word(BEQ_OP, 4, 2, 1));
    prog.push_back(itype_word(BEQ_OP, 0, 0, top - prog.size() - 1));
    run_program();
  endtask

  task automatic test_jump();
    int target;
    prog.delete();
    prog.push_back(itype_word(ADDI_OP, 0, 1, random_imm()));
    target = prog.size() + 3;
    prog.push_back(jump_word(target));
    prog.push_back(itype_word(SW_OP, 0, 1, 'h320));
    prog.push_back(itype_word(SW_OP, 0, 1, 'h324));
    prog.push_back(itype_word(SW_OP, 0, 1, 'h328));
    prog.push_back(itype_word(ADDI_OP, 1, 1, 1));
    prog.push_back(itype_word(SW_OP, 0, 1, 'h32c));
    run_program();
  endtask

  task automatic test_zero_reg();
    prog.delete();
    prog.push_back(itype_word(ADDI_OP, 0, 1, random_imm()));
    prog.push_back(itype_word(ADDI_OP, 0, 0, 'h55));
    prog.push_back(rtype_word(1, 1, 0, ADD_FN));
    prog.push_back(itype_word(SW_OP, 0, 0, 'h340));
    // opcode 0x3f and funct 0x27 lie outside the subset
    prog.push_back({6'h3f, 26'h345678});
    prog.push_back(rtype_word(1, 1, 2, 6'h27));
    prog.push_back(itype_word(SW_OP, 0, 2, 'h344));
    prog.push_back(itype_word(SW_OP, 0, 1, 'h348));
    run_program();
  endtask

  task automatic test_reset();
    prog.delete();
    prog.push_back(itype_word(ADDI_OP, 0, 1, random_imm()));
    prog.push_back(itype_word(ADDI_OP, 0, 2, random_imm()));
    prog.push_back(rtype_word(1, 2, 3, ADD_FN));
    prog.push_back(rtype_word(1, 2, 4, SUB_FN));
    prog.push_back(itype_word(SW_OP, 0, 3, 'h380));
    prog.push_back(itype_word(SW_OP, 0, 4, 'h384));
    prog.push_back(itype_word(SW_OP, 0, 1, 'h388));
    add_halt();
    load_program();
    // stop with the store at word 5 on the bus
    execute(5);
    reset = 1'b1;
    for (int i = 0; i < 4; i++) begin
      #1;
      check_value("dmem_we", 32'd0, 32'(dmem_we));
      if (i > 0) check_value("pc", 32'd0, pc);
      @(negedge clk);
    end
    execute(100);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    reset = 1'b1;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    test_arith();
    test_load_store();
    test_branch();
    test_jump();
    test_zero_reg();
    test_reset();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- project.f
design/mips_pkg.sv
design/mips_interfaces.sv
design/mips_control.sv
design/mips_alu.sv
design/mips_register_file.sv
design/mips_cpu.sv
design/mips_imem.sv
design/mips_dmem.sv
design/mips_top.sv
dv/mips_props.sv
dv/mips_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, then judge the run by its log
rm -f sim.log
verilator --binary --timing --assert --top-module mips_tb -f project.f -o mips_sim \
  && ./obj_dir/mips_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
